// ==== sources.f ====
+incdir+hdl
+incdir+test
hdl/rn_reg_pkg.sv
hdl/rn_bundle_pkg.sv
hdl/rn_rat.sv
hdl/rn_freelist.sv
hdl/rn_retire_q.sv
hdl/rn_top.sv
test/tb_rn_top.sv

// ==== Makefile ====
# Verilator build and run of the rename stage testbench
# Any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rn_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TEST RESULT: FAIL

# Sources and headers that trigger a rebuild
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh test/*.sv test/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Verdict comes from the log so a fatal stop still fails the target
run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_rn_checks.svh ====
// Typed compare tasks for the rename stage testbench
// Included inside tb_rn_top after the package imports
// The first mismatch ends the run
`ifndef TB_RN_CHECKS_SVH
`define TB_RN_CHECKS_SVH

// Print the reason and the verdict and stop
task automatic stop_with_fail(input string why);
   $display("%s", why);
   $display("TEST RESULT: FAIL");
   $fatal(1, "Stopped at the first failed check");
endtask

// One rename slot where destination fields only matter for a writer
task automatic check_rsp(input string name, input ren_rsp_t got, input ren_rsp_t exp,
                         input logic dst);
   ren_rsp_t mask;
   mask = '1;
   if (!dst)
   begin
      mask.prd   = '0;
      mask.pfree = '0;
   end
   if ((got & mask) !== (exp & mask))
      stop_with_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got & mask, exp & mask));
endtask

// One commit slot with payload only while valid and registers only for a writer
task automatic check_commit(input string name, input commit_t got, input commit_t exp);
   commit_t mask;
   mask = '0;
   mask.valid = 1'b1;
   if (exp.valid)
   begin
      mask.lrd    = '1;
      mask.lrd_we = 1'b1;
      if (exp.lrd_we)
      begin
         mask.prd   = '1;
         mask.pfree = '1;
      end
   end
   if ((got & mask) !== (exp & mask))
      stop_with_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got & mask, exp & mask));
endtask

// Slot counts such as the returned credits
task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
   if (got !== exp)
      stop_with_fail($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
endtask

`endif

// ==== test/tb_rn_top.sv ====
// Testbench for the rename stage, one operation per table row
// Rows are a directed part followed by seeded random rows
// Random rows respect credits, occupancy and a lone rollback
// A behavioral model predicts responses, commits and credits
`timescale 1ns/100ps

`include "rn_consts.svh"

module tb_rn_top;

   import rn_reg_pkg::*;
   import rn_bundle_pkg::*;

   typedef enum logic [1:0] {OP_REN, OP_RET, OP_RB} op_e;

   // Stimulus of one cycle with its predicted outputs
   typedef struct packed {
      op_e                          op;
      ren_req_t [`RN_ISSUE_W-1:0]   req;
      cnt_t                         n;
      ren_rsp_t [`RN_ISSUE_W-1:0]   exp_rsp;
      commit_t [`RN_COMMIT_W-1:0]   exp_cmt;
      cnt_t                         exp_cr;
   } row_t;

   localparam int RST_CYCLES = 10;
   localparam int N_CRED     = 1 << `RN_ROB_AW;
   localparam int N_LRF      = 1 << `RN_LRF_AW;

   logic clk;
   logic rst_n;
   logic rollback;
   ren_req_t [`RN_ISSUE_W-1:0] ren_req;
   ren_rsp_t [`RN_ISSUE_W-1:0] ren_rsp;
   cnt_t retire_cnt;
   commit_t [`RN_COMMIT_W-1:0] commit;
   cnt_t credit_ret;

   row_t tbl [$];
   // Sender view while the table is built
   int gen_occ;
   int gen_cred;
   int gen_last;
   // Reference model with tables, a free FIFO from the committed head and a queue
   preg_t m_rat [N_LRF];
   preg_t m_arat [N_LRF];
   preg_t fl_q [$];
   int spec_off;
   commit_t rq [$];
   cnt_t last_ret;
   int cycles = 0;
   int cycle_limit = 0;

   `include "tb_rn_checks.svh"

   rn_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .ren_req    (ren_req),
      .ren_rsp    (ren_rsp),
      .retire_cnt (retire_cnt),
      .commit     (commit),
      .credit_ret (credit_ret)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Limit from the table length
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if ((cycle_limit > 0) && (cycles >= cycle_limit))
         stop_with_fail("Timeout: the stimulus table did not finish within the cycle limit");
   end

   function automatic ren_req_t make_req(input bit v, input int rs1, input int rs2,
                                         input int rd, input bit we);
      return '{valid: v, lrs1: lreg_t'(rs1), lrs2: lreg_t'(rs2), lrd: lreg_t'(rd),
               lrd_we: we};
   endfunction

   // Append a row and follow the credits as the front end sees them
   task automatic add_row(input op_e op, input ren_req_t r0, input ren_req_t r1, input int n);
      row_t row;
      row = '0;
      row.op     = op;
      row.req[0] = r0;
      row.req[1] = r1;
      row.n      = cnt_t'(n);
      tbl.push_back(row);
      // Credits returned this cycle can be spent in it
      gen_cred = gen_cred + gen_last;
      gen_last = 0;
      if (op == OP_REN)
      begin
         gen_cred = gen_cred - int'(r0.valid) - int'(r1.valid);
         gen_occ  = gen_occ + int'(r0.valid) + int'(r1.valid);
      end
      else if (op == OP_RET)
      begin
         gen_occ  = gen_occ - n;
         gen_last = n;
      end
      else
      begin
         gen_occ  = 0;
         gen_cred = N_CRED;
      end
   endtask

   task automatic add_random_row();
      ren_req_t r [`RN_ISSUE_W];
      int pick;
      int room;
      pick = $urandom_range(0, 9);
      room = gen_cred + gen_last;
      if (pick == 0)
         add_row(OP_RB, '0, '0, 0);
      else if ((pick < 5) && (gen_occ > 0))
         add_row(OP_RET, '0, '0, (gen_occ > 1) ? $urandom_range(1, 2) : 1);
      else
      begin
         // Small register range so hazards inside a group are frequent
         for (int i = 0; i < `RN_ISSUE_W; i++)
         begin
            r[i] = make_req(($urandom_range(0, 3) != 0) && (room > 0), $urandom_range(0, 7),
                            $urandom_range(0, 7), $urandom_range(0, 7),
                            $urandom_range(0, 3) != 0);
            if (r[i].valid)
               room--;
         end
         add_row(OP_REN, r[0], r[1], 0);
      end
   endtask

   task automatic build_table();
      gen_occ  = 0;
      gen_cred = N_CRED;
      gen_last = 0;
      // Identity map after reset so the writers take 32 and 33
      add_row(OP_REN, make_req(1, 3, 7, 1, 1), make_req(1, 7, 3, 2, 1), 0);
      // RAW on both sources of slot 1
      add_row(OP_REN, make_req(1, 1, 2, 10, 1), make_req(1, 10, 10, 11, 1), 0);
      // Slot 0 does not write so slot 1 reads the table
      add_row(OP_REN, make_req(1, 4, 5, 12, 0), make_req(1, 12, 12, 13, 1), 0);
      // WAW in one group then a read of the survivor
      add_row(OP_REN, make_req(1, 6, 6, 20, 1), make_req(1, 8, 9, 20, 1), 0);
      add_row(OP_REN, make_req(1, 20, 20, 21, 1), make_req(0, 0, 0, 0, 0), 0);
      add_row(OP_RET, '0, '0, 2);
      add_row(OP_RET, '0, '0, 1);
      add_row(OP_RET, '0, '0, 2);
      // Speculative work thrown away by the rollback
      add_row(OP_REN, make_req(1, 2, 3, 1, 1), make_req(1, 1, 1, 10, 1), 0);
      add_row(OP_RB, '0, '0, 0);
      add_row(OP_REN, make_req(1, 1, 10, 1, 1), make_req(1, 20, 13, 3, 1), 0);
      // Churn past the initial 32 so freed registers come back
      for (int i = 0; i < 14; i++)
      begin
         add_row(OP_REN, make_req(1, i, i + 1, i % 8, 1),
                 make_req(1, i % 8, i + 2, (i + 3) % 8, 1), 0);
         add_row(OP_RET, '0, '0, 2);
      end
      for (int i = 0; i < 40; i++)
         add_random_row();
   endtask

   task automatic reset_model();
      for (int i = 0; i < N_LRF; i++)
      begin
         m_rat[i]  = preg_t'(i);
         m_arat[i] = preg_t'(i);
      end
      for (int i = 0; i < `RN_FL_DEPTH; i++)
         fl_q.push_back(preg_t'(N_LRF + i));
      spec_off = 0;
      last_ret = '0;
   endtask

   // Fill the expected outputs and move the model past the edge
   task automatic predict(inout row_t row);
      commit_t e;
      row.exp_cr  = last_ret;
      row.exp_rsp = '0;
      row.exp_cmt = '0;
      last_ret    = '0;
      case (row.op)
         OP_REN:
            // Slots in order against a running table gives RAW and WAW
            for (int i = 0; i < `RN_ISSUE_W; i++)
               if (row.req[i].valid)
               begin
                  row.exp_rsp[i].prs1 = m_rat[row.req[i].lrs1];
                  row.exp_rsp[i].prs2 = m_rat[row.req[i].lrs2];
                  if (row.req[i].lrd_we)
                  begin
                     row.exp_rsp[i].pfree = m_rat[row.req[i].lrd];
                     row.exp_rsp[i].prd   = fl_q[spec_off];
                     spec_off++;
                     m_rat[row.req[i].lrd] = row.exp_rsp[i].prd;
                  end
                  e = '{valid: 1'b1, lrd: row.req[i].lrd, lrd_we: row.req[i].lrd_we,
                        prd: row.exp_rsp[i].prd, pfree: row.exp_rsp[i].pfree};
                  rq.push_back(e);
               end
         OP_RET:
         begin
            for (int k = 0; k < int'(row.n); k++)
            begin
               e = rq.pop_front();
               row.exp_cmt[k] = e;
               // Committed head moves on and the displaced register goes to the tail
               if (e.lrd_we)
               begin
                  m_arat[e.lrd] = e.prd;
                  void'(fl_q.pop_front());
                  spec_off--;
                  fl_q.push_back(e.pfree);
               end
            end
            last_ret = row.n;
         end
         default:
         begin
            m_rat    = m_arat;
            spec_off = 0;
            rq.delete();
         end
      endcase
   endtask

   initial
   begin
      row_t row;
      void'($urandom(26960));
      rst_n      = 1'b0;
      rollback   = 1'b0;
      ren_req    = '0;
      retire_cnt = '0;
      build_table();
      cycle_limit = 2 * tbl.size() + RST_CYCLES;
      reset_model();
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      foreach (tbl[r])
      begin
         row = tbl[r];
         predict(row);
         rollback   = (row.op == OP_RB);
         ren_req    = (row.op == OP_REN) ? row.req : '0;
         retire_cnt = (row.op == OP_RET) ? row.n : '0;
         // Mid-cycle well after the drive and before the edge
         @(negedge clk);
         for (int i = 0; i < `RN_ISSUE_W; i++)
            if (ren_req[i].valid)
               check_rsp($sformatf("ren_rsp[%0d] row %0d", i, r), ren_rsp[i],
                         row.exp_rsp[i], ren_req[i].lrd_we);
         for (int k = 0; k < `RN_COMMIT_W; k++)
            check_commit($sformatf("commit[%0d] row %0d", k, r), commit[k], row.exp_cmt[k]);
         check_cnt($sformatf("credit_ret row %0d", r), credit_ret, row.exp_cr);
         @(posedge clk);
         #2;
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== hdl/rn_top.sv ====
// Rename stage top with RAT, free list and retire queue
// Front end flow control is by credits only and there is no stall
// ren_rsp and commit are combinational while credit_ret is registered
// Rollback is a one-cycle pulse with no rename or retire in that cycle
`timescale 1ns/100ps

`include "rn_consts.svh"

module rn_top
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         rollback,
   input  rn_bundle_pkg::ren_req_t [`RN_ISSUE_W-1:0]    ren_req,
   output rn_bundle_pkg::ren_rsp_t [`RN_ISSUE_W-1:0]    ren_rsp,
   input  rn_reg_pkg::cnt_t                             retire_cnt,
   output rn_bundle_pkg::commit_t [`RN_COMMIT_W-1:0]    commit,
   output rn_reg_pkg::cnt_t                             credit_ret
);

   import rn_reg_pkg::*;

   // Next free registers for the writing slots
   preg_t [`RN_ISSUE_W-1:0] fl_prd;
   // Registers taken from the free list this cycle
   cnt_t alloc_cnt;

   always_comb
   begin
      alloc_cnt = '0;
      for (int i = 0; i < `RN_ISSUE_W; i++)
         alloc_cnt = alloc_cnt + cnt_t'(ren_req[i].valid && ren_req[i].lrd_we);
   end

   rn_rat u_rat (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .ren_req    (ren_req),
      .fl_prd     (fl_prd),
      .commit     (commit),
      .ren_rsp    (ren_rsp)
   );

   rn_freelist u_freelist (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .alloc_cnt  (alloc_cnt),
      .commit     (commit),
      .fl_prd     (fl_prd)
   );

   rn_retire_q u_retire_q (
      .clk        (clk),
      .rst_n      (rst_n),
      .rollback   (rollback),
      .ren_req    (ren_req),
      .ren_rsp    (ren_rsp),
      .retire_cnt (retire_cnt),
      .commit     (commit),
      .credit_ret (credit_ret)
   );

endmodule

// ==== hdl/rn_retire_q.sv ====
// In-order retire queue with one credit per entry
// retire_cnt comes from outside and must not exceed the occupancy
// Rollback drops every uncommitted entry and returns no credits for them
// Commit payload is defined only for entries between head and tail
`timescale 1ns/100ps

`include "rn_consts.svh"

module rn_retire_q
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         rollback,
   input  rn_bundle_pkg::ren_req_t [`RN_ISSUE_W-1:0]    ren_req,
   input  rn_bundle_pkg::ren_rsp_t [`RN_ISSUE_W-1:0]    ren_rsp,
   input  rn_reg_pkg::cnt_t                             retire_cnt,
   output rn_bundle_pkg::commit_t [`RN_COMMIT_W-1:0]    commit,
   output rn_reg_pkg::cnt_t                             credit_ret
);

   import rn_reg_pkg::*;

   localparam int RQ_DEPTH = 1 << `RN_ROB_AW;

   typedef logic [`RN_ROB_AW-1:0] rq_idx_t;

   // Stored part of a renamed instruction
   typedef struct packed {
      lreg_t lrd;
      logic  lrd_we;
      preg_t prd;
      preg_t pfree;
   } rq_ent_t;

   rq_ent_t rq_mem [RQ_DEPTH];

   rq_ptr_t head;
   rq_ptr_t tail;
   rq_ptr_t occ;

   logic [`RN_ISSUE_W-1:0] enq_we;
   rq_idx_t enq_idx [`RN_ISSUE_W];
   cnt_t enq_cnt;

   assign occ = tail - head;

   // Valid slots fill consecutive entries from the tail
   always_comb
   begin
      enq_cnt = '0;
      for (int i = 0; i < `RN_ISSUE_W; i++)
      begin
         enq_we[i]  = ren_req[i].valid;
         enq_idx[i] = tail[`RN_ROB_AW-1:0] + rq_idx_t'(enq_cnt);
         enq_cnt    = enq_cnt + cnt_t'(enq_we[i]);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `RN_ISSUE_W; i++)
         if (enq_we[i])
            rq_mem[enq_idx[i]] <= {ren_req[i].lrd, ren_req[i].lrd_we,
                                   ren_rsp[i].prd, ren_rsp[i].pfree};
   end

   // Head entries shown combinationally and valid only while retiring
   always_comb
   begin
      rq_idx_t idx;
      for (int k = 0; k < `RN_COMMIT_W; k++)
      begin
         idx             = head[`RN_ROB_AW-1:0] + rq_idx_t'(k);
         commit[k].valid = (cnt_t'(k) < retire_cnt) && (rq_ptr_t'(k) < occ);
         commit[k].lrd    = rq_mem[idx].lrd;
         commit[k].lrd_we = rq_mem[idx].lrd_we;
         commit[k].prd    = rq_mem[idx].prd;
         commit[k].pfree  = rq_mem[idx].pfree;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head       <= '0;
         tail       <= '0;
         credit_ret <= '0;
      end
      else
      begin
         head       <= head + rq_ptr_t'(retire_cnt);
         // Credits go back one cycle after retirement
         credit_ret <= retire_cnt;
         if (rollback)
            tail <= head;
         else
            tail <= tail + rq_ptr_t'(enq_cnt);
      end
   end

   // Front end spends credits correctly so the queue never overflows
   a_rq_no_ovf: assert property (@(posedge clk) disable iff (!rst_n)
      (occ + rq_ptr_t'(enq_cnt)) <= rq_ptr_t'(RQ_DEPTH));

   // Retirement never reaches past the tail
   a_rq_retire: assert property (@(posedge clk) disable iff (!rst_n)
      rq_ptr_t'(retire_cnt) <= occ);

   // Rollback stands alone in its cycle
   a_rq_rb_alone: assert property (@(posedge clk) disable iff (!rst_n)
      rollback |-> ((enq_cnt == '0) && (retire_cnt == '0)));

endmodule

// ==== hdl/rn_freelist.sv ====
// Circular free list of physical registers
// Resets holding the registers above the architectural set in ascending order
// Never runs dry while the retire queue is smaller than the list
// Only retiring writers return a register
`timescale 1ns/100ps

`include "rn_consts.svh"

module rn_freelist
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         rollback,
   input  rn_reg_pkg::cnt_t                             alloc_cnt,
   input  rn_bundle_pkg::commit_t [`RN_COMMIT_W-1:0]    commit,
   output rn_reg_pkg::preg_t [`RN_ISSUE_W-1:0]          fl_prd
);

   import rn_reg_pkg::*;

   localparam int FL_IW  = $clog2(`RN_FL_DEPTH);
   localparam int N_ARCH = 1 << `RN_LRF_AW;

   typedef logic [FL_IW-1:0] fl_idx_t;

   preg_t fl_mem [`RN_FL_DEPTH];

   // Speculative read, committed read and write pointers
   fl_ptr_t spec_rd;
   fl_ptr_t cmt_rd;
   fl_ptr_t wr_ptr;
   // Registers not yet handed out
   fl_ptr_t fl_cnt;

   logic [`RN_COMMIT_W-1:0] rel_we;
   fl_idx_t rel_idx [`RN_COMMIT_W];
   cnt_t rel_cnt;

   // Next free entries from the speculative head
   always_comb
   begin
      for (int i = 0; i < `RN_ISSUE_W; i++)
         fl_prd[i] = fl_mem[spec_rd[FL_IW-1:0] + fl_idx_t'(i)];
   end

   // Pack released registers behind the tail in retire order
   always_comb
   begin
      rel_cnt = '0;
      for (int k = 0; k < `RN_COMMIT_W; k++)
      begin
         rel_we[k]  = commit[k].valid && commit[k].lrd_we;
         rel_idx[k] = wr_ptr[FL_IW-1:0] + fl_idx_t'(rel_cnt);
         rel_cnt    = rel_cnt + cnt_t'(rel_we[k]);
      end
   end

   assign fl_cnt = wr_ptr - spec_rd;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `RN_FL_DEPTH; i++)
            fl_mem[i] <= preg_t'(N_ARCH + i);
      end
      else
      begin
         for (int k = 0; k < `RN_COMMIT_W; k++)
            if (rel_we[k])
               fl_mem[rel_idx[k]] <= commit[k].pfree;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         spec_rd <= '0;
         cmt_rd  <= '0;
         // Full list with the write pointer one lap ahead
         wr_ptr  <= fl_ptr_t'(`RN_FL_DEPTH);
      end
      else
      begin
         wr_ptr <= wr_ptr + fl_ptr_t'(rel_cnt);
         // Each retiring writer consumed one entry at rename
         cmt_rd <= cmt_rd + fl_ptr_t'(rel_cnt);
         if (rollback)
            spec_rd <= cmt_rd;
         else
            spec_rd <= spec_rd + fl_ptr_t'(alloc_cnt);
      end
   end

   // Occupancy bounds and no allocation beyond what is free
   a_fl_occ: assert property (@(posedge clk) disable iff (!rst_n)
      (fl_cnt <= fl_ptr_t'(`RN_FL_DEPTH)) && (fl_ptr_t'(alloc_cnt) <= fl_cnt));

   // Committed head never passes the speculative head
   a_fl_cmt: assert property (@(posedge clk) disable iff (!rst_n)
      (spec_rd - cmt_rd) <= fl_ptr_t'(`RN_FL_DEPTH));

endmodule

// ==== hdl/rn_rat.sv ====
// Speculative and architectural register alias tables
// Both tables reset to the identity map and logical 0 is renamed normally
// Free registers arrive in order and writing slots take them in slot order
// Rollback must not share a cycle with a valid rename slot
`timescale 1ns/100ps

`include "rn_consts.svh"

module rn_rat
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         rollback,
   input  rn_bundle_pkg::ren_req_t [`RN_ISSUE_W-1:0]    ren_req,
   input  rn_reg_pkg::preg_t [`RN_ISSUE_W-1:0]          fl_prd,
   input  rn_bundle_pkg::commit_t [`RN_COMMIT_W-1:0]    commit,
   output rn_bundle_pkg::ren_rsp_t [`RN_ISSUE_W-1:0]    ren_rsp
);

   import rn_reg_pkg::*;

   localparam int N_LRF = 1 << `RN_LRF_AW;

   // Mapping tables indexed by logical register
   preg_t spec_rat [N_LRF];
   preg_t arat [N_LRF];

   // Slot writes a destination this cycle
   logic [`RN_ISSUE_W-1:0] slot_we;
   // New physical register handed to each slot
   preg_t new_prd [`RN_ISSUE_W];

   // Compact the free entries onto the writing slots
   always_comb
   begin
      logic [$clog2(`RN_ISSUE_W)-1:0] n_wr;
      n_wr = '0;
      for (int i = 0; i < `RN_ISSUE_W; i++)
      begin
         slot_we[i] = ren_req[i].valid && ren_req[i].lrd_we;
         new_prd[i] = fl_prd[n_wr];
         if (slot_we[i])
            n_wr = n_wr + 1'b1;
      end
   end

   // Table lookup then in-group bypass
   // Later older slots override earlier ones so the nearest writer wins
   always_comb
   begin
      for (int i = 0; i < `RN_ISSUE_W; i++)
      begin
         ren_rsp[i].prs1  = spec_rat[ren_req[i].lrs1];
         ren_rsp[i].prs2  = spec_rat[ren_req[i].lrs2];
         ren_rsp[i].pfree = spec_rat[ren_req[i].lrd];
         ren_rsp[i].prd   = new_prd[i];
         for (int j = 0; j < i; j++)
         begin
            // RAW on an older slot's destination
            if (slot_we[j] && (ren_req[j].lrd == ren_req[i].lrs1))
               ren_rsp[i].prs1 = new_prd[j];
            if (slot_we[j] && (ren_req[j].lrd == ren_req[i].lrs2))
               ren_rsp[i].prs2 = new_prd[j];
            // WAW frees the older slot's new register on retirement
            if (slot_we[j] && (ren_req[j].lrd == ren_req[i].lrd))
               ren_rsp[i].pfree = new_prd[j];
         end
      end
   end

   // Speculative table
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < N_LRF; i++)
            spec_rat[i] <= preg_t'(i);
      end
      else if (rollback)
      begin
         // Back to the committed view
         for (int i = 0; i < N_LRF; i++)
            spec_rat[i] <= arat[i];
      end
      else
      begin
         // Slot order so the youngest writer of a register wins
         for (int i = 0; i < `RN_ISSUE_W; i++)
            if (slot_we[i])
               spec_rat[ren_req[i].lrd] <= new_prd[i];
      end
   end

   // Architectural table follows retirement
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < N_LRF; i++)
            arat[i] <= preg_t'(i);
      end
      else
      begin
         for (int k = 0; k < `RN_COMMIT_W; k++)
            if (commit[k].valid && commit[k].lrd_we)
               arat[commit[k].lrd] <= commit[k].prd;
      end
   end

   // Oldest retiring writer displaces exactly the committed mapping
   a_arat_pfree: assert property (@(posedge clk) disable iff (!rst_n)
      (commit[0].valid && commit[0].lrd_we) |-> (arat[commit[0].lrd] == commit[0].pfree));

endmodule

// ==== hdl/rn_bundle_pkg.sv ====
// Per-slot bundles between front end, rename and retirement
// Ports carry packed arrays of these with slot 0 as the oldest
// No field here is meaningful unless its valid bit is set

package rn_bundle_pkg;

   import rn_reg_pkg::*;

   // Rename request for one instruction
   typedef struct packed {
      logic  valid;
      lreg_t lrs1;
      lreg_t lrs2;
      lreg_t lrd;
      logic  lrd_we;
   } ren_req_t;

   // Rename result for one slot
   // prd and pfree only matter when the slot writes
   typedef struct packed {
      preg_t prs1;
      preg_t prs2;
      preg_t prd;
      preg_t pfree;
   } ren_rsp_t;

   // Retiring entry as seen by the ARAT and the free list
   typedef struct packed {
      logic  valid;
      lreg_t lrd;
      logic  lrd_we;
      preg_t prd;
      preg_t pfree;
   } commit_t;

endpackage

// ==== hdl/rn_reg_pkg.sv ====
// Register index, pointer and count types for the rename stage
// Pointer types carry one wrap bit above the index bits
// Widths follow the constants header

`include "rn_consts.svh"

package rn_reg_pkg;

   // Logical register index
   typedef logic [`RN_LRF_AW-1:0] lreg_t;

   // Physical register index
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   // Retire-queue pointer with wrap bit on top
   typedef logic [`RN_ROB_AW:0] rq_ptr_t;

   // Free-list pointer with wrap bit on top
   typedef logic [$clog2(`RN_FL_DEPTH):0] fl_ptr_t;

   // Per-cycle slot count from 0 to 2
   typedef logic [$clog2(`RN_ISSUE_W):0] cnt_t;

endpackage

// ==== hdl/rn_consts.svh ====
// Sizing constants for the rename stage
// The design is built for this one size only
// RN_FL_DEPTH must equal physical minus logical register count
// Retire-queue depth must stay below RN_FL_DEPTH or allocation could run dry
`ifndef RN_CONSTS_SVH
`define RN_CONSTS_SVH

// Logical register index width for 32 architectural registers
`define RN_LRF_AW 5
// Physical register index width for 64 physical registers
`define RN_PRF_AW 6
// Rename slots per cycle
`define RN_ISSUE_W 2
// Retire slots per cycle
`define RN_COMMIT_W 2
// Retire-queue index width gives 16 entries and 16 credits
`define RN_ROB_AW 4
// Free registers beyond the architectural set
`define RN_FL_DEPTH 32

`endif
